//--- verilog.f
rtl/meshPkg.sv
rtl/linkIf.sv
rtl/linkFifo.sv
rtl/bootLoader.sv
rtl/nodeRouter.sv
rtl/meshNode.sv
rtl/meshTop.sv
verification/meshTop_chk.sv
verification/meshTb.sv

//--- Bender.yml
package:
  name: mesh

sources:
  - files:
      - rtl/meshPkg.sv
      - rtl/linkIf.sv
      - rtl/linkFifo.sv
      - rtl/bootLoader.sv
      - rtl/nodeRouter.sv
      - rtl/meshNode.sv
      - rtl/meshTop.sv
  - target: test
    files:
      - verification/meshTop_chk.sv
      - verification/meshTb.sv

//--- verification/meshTb.sv
module meshTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int Nodes = meshPkg::MeshNodes;
	localparam int Depth = meshPkg::LoadDepth;
	localparam int IdleLimit = 1000;

	logic clk;
	logic rstN;
	meshPkg::nodeSel_t processorSelect;
	meshPkg::word_t bootData;
	logic bootWe;
	logic outRd;
	logic outEmpty;
	meshPkg::word_t outData;

	// Reference model, kept words per source node
	meshPkg::word_t expWords [Nodes][Depth];
	meshPkg::loadCnt_t expCnt [Nodes];
	meshPkg::loadCnt_t gotCnt [Nodes];

	logic [31:0] lfsrState = 32'h6029154e;

	meshTop i_dut (
		.clk(clk),
		.rstN(rstN),
		.processorSelect(processorSelect),
		.bootData(bootData),
		.bootWe(bootWe),
		.outRd(outRd),
		.outEmpty(outEmpty),
		.outData(outData)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Taps 32, 22, 2, 1
	function automatic logic lfsrStep();
		logic fb;
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsrStep()};
		end
		return v;
	endfunction

	// Source node on top, then sequence number, then random filler
	function automatic meshPkg::word_t makePayload(input int node, input int seq);
		logic [31:0] r;
		r = randBits(meshPkg::WordWidth - 8);
		return {4'(node), 4'(seq), r[meshPkg::WordWidth-9:0]};
	endfunction

	task automatic stopRun();
		$display("=== FAIL ===");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic flagError(input string msg);
		$display("FAILED at %0d ns: %s", $time, msg);
		stopRun();
	endtask

	task automatic waitExpired(input string msg);
		$display("Timed out: %s", msg);
		stopRun();
	endtask

	task automatic compareWord(input meshPkg::word_t got, input meshPkg::word_t exp,
		input string what);
		if (got !== exp) begin
			flagError($sformatf("%s: got %h, expected %h", what, got, exp));
		end
	endtask

	task automatic compareCount(input meshPkg::loadCnt_t got, input meshPkg::loadCnt_t exp,
		input string what);
		if (got !== exp) begin
			flagError($sformatf("%s: got %0d, expected %0d", what, got, exp));
		end
	endtask

	task automatic compareFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			flagError($sformatf("%s: got %b, expected %b", what, got, exp));
		end
	endtask

	task automatic resetDut();
		rstN = 1'b0;
		processorSelect = '0;
		bootData = '0;
		bootWe = 1'b0;
		outRd = 1'b0;
		for (int n = 0; n < Nodes; n++) begin
			expCnt[n] = '0;
			gotCnt[n] = '0;
		end
		repeat (8) @(posedge clk);
		#1;
		rstN = 1'b1;
	endtask

	// One boot cycle, held until the next call
	task automatic bootWrite(input meshPkg::nodeSel_t sel, input logic we,
		input meshPkg::word_t data);
		@(posedge clk);
		#1;
		processorSelect = sel;
		bootWe = we;
		bootData = data;
	endtask

	task automatic loadNode(input int node, input int count);
		meshPkg::word_t w;
		for (int k = 0; k < count; k++) begin
			w = makePayload(node, k);
			bootWrite(meshPkg::nodeSel_t'(node), 1'b1, w);
			// A node keeps only its first Depth words
			if (k < Depth) begin
				expWords[node][k] = w;
				expCnt[node] = expCnt[node] + 1'b1;
			end
		end
	endtask

	task automatic startRun();
		bootWrite(meshPkg::nodeSel_t'(Nodes), 1'b0, '0);
	endtask

	// Pops every expected word, order checked per source
	task automatic collectWords();
		int total;
		int got;
		int idle;
		meshPkg::word_t w;
		meshPkg::nodeSel_t src;
		total = 0;
		got = 0;
		idle = 0;
		for (int n = 0; n < Nodes; n++) begin
			total += expCnt[n];
		end
		while (got < total) begin
			@(posedge clk);
			#1;
			if (!outEmpty) begin
				w = outData;
				outRd = 1'b1;
				src = w[meshPkg::WordWidth-1 -: 4];
				if (src >= Nodes) begin
					flagError($sformatf("word %h names no node", w));
				end
				// Surplus words from a source are left to the per-node counts
				if (gotCnt[src] < expCnt[src]) begin
					compareWord(w, expWords[src][gotCnt[src]],
						$sformatf("word %0d from node %0d", gotCnt[src], src));
				end
				gotCnt[src] = gotCnt[src] + 1'b1;
				got++;
				idle = 0;
			end else begin
				outRd = 1'b0;
				idle++;
				if (idle > IdleLimit) begin
					waitExpired($sformatf("word %0d of %0d never arrived", got + 1, total));
				end
			end
		end
		// Last pop happens at this edge
		@(posedge clk);
		#1;
		outRd = 1'b0;
	endtask

	task automatic checkCounts();
		for (int n = 0; n < Nodes; n++) begin
			compareCount(gotCnt[n], expCnt[n], $sformatf("words from node %0d", n));
		end
	endtask

	task automatic quietCheck(input int cycles, input string what);
		outRd = 1'b0;
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			#1;
			compareFlag(outEmpty, 1'b1, what);
		end
	endtask

	task automatic idleAfterReset();
		resetDut();
		startRun();
		quietCheck(100, "outEmpty with nothing loaded");
	endtask

	task automatic nodeZeroOrder();
		resetDut();
		loadNode(0, 3);
		startRun();
		collectWords();
		checkCounts();
		quietCheck(50, "outEmpty after node 0 drained");
	endtask

	task automatic allNodesDelivery();
		resetDut();
		for (int n = 0; n < Nodes; n++) begin
			loadNode(n, 1 + randBits(3));
		end
		startRun();
		collectWords();
		checkCounts();
		quietCheck(100, "outEmpty after all nodes drained");
	endtask

	task automatic overfillFarNode();
		resetDut();
		loadNode(Nodes - 1, Depth + 2);
		startRun();
		collectWords();
		checkCounts();
		quietCheck(100, "outEmpty after overfilled node drained");
	endtask

	task automatic backPressure();
		resetDut();
		for (int n = 0; n < Nodes; n++) begin
			loadNode(n, 1 + randBits(3));
		end
		startRun();
		// Mesh fills up behind the stalled output
		repeat (200) @(posedge clk);
		collectWords();
		checkCounts();
		quietCheck(100, "outEmpty after back-pressure drain");
	endtask

	task automatic ignoredWrites();
		resetDut();
		bootWrite(4'd0, 1'b0, makePayload(0, 0));
		bootWrite(4'd5, 1'b0, makePayload(5, 0));
		bootWrite(4'd11, 1'b0, makePayload(11, 0));
		bootWrite(4'd13, 1'b1, makePayload(13, 0));
		bootWrite(4'd14, 1'b1, makePayload(14, 0));
		bootWrite(4'd15, 1'b1, makePayload(15, 0));
		startRun();
		quietCheck(100, "outEmpty after ignored writes");
	endtask

	initial begin
		rstN = 1'b0;
		processorSelect = '0;
		bootData = '0;
		bootWe = 1'b0;
		outRd = 1'b0;
		idleAfterReset();
		nodeZeroOrder();
		allNodesDelivery();
		overfillFarNode();
		backPressure();
		ignoredWrites();
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- verification/meshTop_chk.sv
module meshTop_chk (
	input logic clk,
	input logic rstN,
	input meshPkg::nodeMask_t nodeWe,
	input logic run,
	input logic outEmpty,
	input meshPkg::nodeMask_t linkWr,
	input meshPkg::nodeMask_t linkFull
);
	timeunit 1ns;
	timeprecision 100ps;

	// At most one node takes a boot word per cycle
	assert property (@(posedge clk) disable iff (!rstN) $onehot0(nodeWe))
		else $error("More than one node write strobe active");

	// Routers hold off while their output FIFO is full
	assert property (@(posedge clk) disable iff (!rstN) (linkWr & linkFull) == '0)
		else $error("Link FIFO written while full");

	// Eject FIFO comes out of reset empty
	assert property (@(posedge clk) $rose(rstN) |-> outEmpty)
		else $error("Output not empty after reset");

	// Boot and run are decoded from the same select
	assert property (@(posedge clk) disable iff (!rstN) !(run && (nodeWe != '0)))
		else $error("Run active together with a node write strobe");

endmodule

bind meshTop meshTop_chk iChk (
	.clk(clk),
	.rstN(rstN),
	.nodeWe(nodeWe),
	.run(run),
	.outEmpty(outEmpty),
	.linkWr({link[11].wr, link[10].wr, link[9].wr, link[8].wr, link[7].wr, link[6].wr,
		link[5].wr, link[4].wr, link[3].wr, link[2].wr, link[1].wr, link[0].wr}),
	.linkFull({link[11].full, link[10].full, link[9].full, link[8].full, link[7].full,
		link[6].full, link[5].full, link[4].full, link[3].full, link[2].full,
		link[1].full, link[0].full})
);

//--- rtl/meshTop.sv
module meshTop #(
	parameter int MeshCols = meshPkg::MeshCols,
	parameter int MeshRows = meshPkg::MeshRows,
	parameter int LoadDepth = meshPkg::LoadDepth,
	parameter int LinkDepth = meshPkg::LinkDepth
) (
	input logic clk,
	input logic rstN,
	input meshPkg::nodeSel_t processorSelect,
	input meshPkg::word_t bootData,
	input logic bootWe,
	input logic outRd,
	output logic outEmpty,
	output meshPkg::word_t outData
);

	localparam int Nodes = MeshCols * MeshRows;
	// One idle link per missing east or north input
	localparam int Ties = Nodes + 1;

	meshPkg::nodeMask_t nodeWe;
	meshPkg::word_t nodeData;
	logic run;

	// Link i is the output FIFO of node i, the rest are idle edge links
	linkIf link [Nodes + Ties] ();

	bootLoader #(
		.Nodes(Nodes)
	) iBootLoader (
		.clk(clk),
		.rstN(rstN),
		.processorSelect(processorSelect),
		.bootData(bootData),
		.bootWe(bootWe),
		.nodeWe(nodeWe),
		.nodeData(nodeData),
		.run(run)
	);

	for (genvar r = 0; r < MeshRows; r++) begin : gRow
		for (genvar c = 0; c < MeshCols; c++) begin : gCol
			localparam int Idx = r * MeshCols + c;
			localparam int EastIdx = (c < MeshCols - 1) ? Idx + 1 : Nodes + r;
			localparam int NorthIdx = (c == 0 && r < MeshRows - 1) ? Idx + MeshCols :
				(c > 0) ? Nodes + MeshRows + r * (MeshCols - 1) + c - 1 : 2 * Nodes;

			meshNode #(
				.Col(c),
				.Row(r),
				.MeshCols(MeshCols),
				.MeshRows(MeshRows),
				.LoadDepth(LoadDepth)
			) iNode (
				.clk(clk),
				.rstN(rstN),
				.loadWe(nodeWe[Idx]),
				.loadData(nodeData),
				.run(run),
				.outLink(link[Idx]),
				.eastIn(link[EastIdx]),
				.northIn(link[NorthIdx])
			);

			// West link, south link in column 0, eject FIFO at node 0
			linkFifo #(
				.Depth(LinkDepth)
			) iFifo (
				.clk(clk),
				.rstN(rstN),
				.link(link[Idx])
			);
		end
	end

	// Edge links carry nothing
	for (genvar t = Nodes; t < Nodes + Ties; t++) begin : gTie
		assign link[t].empty = 1'b1;
		assign link[t].rData = '0;
	end

	// Eject FIFO read side goes to the host
	assign link[0].rd = outRd;
	assign outEmpty = link[0].empty;
	assign outData = link[0].rData;

endmodule

//--- rtl/meshNode.sv
module meshNode #(
	parameter int Col = 0,
	parameter int Row = 0,
	parameter int MeshCols = meshPkg::MeshCols,
	parameter int MeshRows = meshPkg::MeshRows,
	parameter int LoadDepth = meshPkg::LoadDepth
) (
	input logic clk,
	input logic rstN,
	input logic loadWe,
	input meshPkg::word_t loadData,
	input logic run,
	linkIf.sender outLink,
	linkIf.receiver eastIn,
	linkIf.receiver northIn
);

	// Only column 0 forwards southward, so only it sees a north input
	localparam bit HasEast = (Col < MeshCols - 1);
	localparam bit HasNorth = (Col == 0) && (Row < MeshRows - 1);
	localparam int AddrW = (LoadDepth > 1) ? $clog2(LoadDepth) : 1;

	meshPkg::word_t sendMem [LoadDepth];
	meshPkg::loadCnt_t fillCnt;
	meshPkg::loadCnt_t injPtr;
	logic loadAccept;
	logic localValid;
	logic localTaken;

	// Writes past LoadDepth are dropped
	assign loadAccept = loadWe && (fillCnt < LoadDepth);

	always_ff @(posedge clk) begin
		if (loadAccept) begin
			sendMem[fillCnt[AddrW-1:0]] <= loadData;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			fillCnt <= '0;
			injPtr <= '0;
		end else begin
			if (loadAccept) begin
				fillCnt <= fillCnt + 1'b1;
			end
			if (localTaken) begin
				injPtr <= injPtr + 1'b1;
			end
		end
	end

	assign localValid = run && (injPtr < fillCnt);

	nodeRouter #(
		.HasEast(HasEast),
		.HasNorth(HasNorth)
	) iRouter (
		.clk(clk),
		.rstN(rstN),
		.localValid(localValid),
		.localData(sendMem[injPtr[AddrW-1:0]]),
		.localTaken(localTaken),
		.eastIn(eastIn),
		.northIn(northIn),
		.outLink(outLink)
	);

endmodule

//--- rtl/nodeRouter.sv
module nodeRouter #(
	parameter bit HasEast = 1'b1,
	parameter bit HasNorth = 1'b1
) (
	input logic clk,
	input logic rstN,
	input logic localValid,
	input meshPkg::word_t localData,
	output logic localTaken,
	linkIf.receiver eastIn,
	linkIf.receiver northIn,
	linkIf.sender outLink
);

	meshPkg::rrState_t lastGrant;
	meshPkg::rrState_t nextGrant;
	logic reqEast;
	logic reqNorth;
	logic anyGrant;

	// Inputs past the mesh edge never request
	assign reqEast = HasEast && !eastIn.empty;
	assign reqNorth = HasNorth && !northIn.empty;
	assign anyGrant = !outLink.full && (localValid || reqEast || reqNorth);

	// Search starts at the input after the last grant
	always_comb begin
		nextGrant = lastGrant;
		case (lastGrant)
			meshPkg::grantLocal: begin
				if (reqEast) nextGrant = meshPkg::grantEast;
				else if (reqNorth) nextGrant = meshPkg::grantNorth;
				else if (localValid) nextGrant = meshPkg::grantLocal;
			end
			meshPkg::grantEast: begin
				if (reqNorth) nextGrant = meshPkg::grantNorth;
				else if (localValid) nextGrant = meshPkg::grantLocal;
				else if (reqEast) nextGrant = meshPkg::grantEast;
			end
			default: begin
				if (localValid) nextGrant = meshPkg::grantLocal;
				else if (reqEast) nextGrant = meshPkg::grantEast;
				else if (reqNorth) nextGrant = meshPkg::grantNorth;
			end
		endcase
	end

	assign localTaken = anyGrant && (nextGrant == meshPkg::grantLocal);
	assign eastIn.rd = anyGrant && (nextGrant == meshPkg::grantEast);
	assign northIn.rd = anyGrant && (nextGrant == meshPkg::grantNorth);

	assign outLink.wr = anyGrant;

	always_comb begin
		case (nextGrant)
			meshPkg::grantEast: outLink.wData = eastIn.rData;
			meshPkg::grantNorth: outLink.wData = northIn.rData;
			default: outLink.wData = localData;
		endcase
	end

	// Round-robin pointer only moves on a grant
	always_ff @(posedge clk) begin
		if (!rstN) begin
			lastGrant <= meshPkg::grantLocal;
		end else if (anyGrant) begin
			lastGrant <= nextGrant;
		end
	end

endmodule

//--- rtl/bootLoader.sv
module bootLoader #(
	parameter int Nodes = meshPkg::MeshNodes
) (
	input logic clk,
	input logic rstN,
	input meshPkg::nodeSel_t processorSelect,
	input meshPkg::word_t bootData,
	input logic bootWe,
	output meshPkg::nodeMask_t nodeWe,
	output meshPkg::word_t nodeData,
	output logic run
);

	meshPkg::nodeSel_t selQ;
	logic weQ;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			selQ <= '0;
			weQ <= 1'b0;
		end else begin
			selQ <= processorSelect;
			weQ <= bootWe;
		end
	end

	always_ff @(posedge clk) begin
		nodeData <= bootData;
	end

	// One-hot strobe for a node select, nothing for run or 13 and up
	always_comb begin
		nodeWe = '0;
		if (weQ && (selQ < Nodes)) begin
			nodeWe[selQ] = 1'b1;
		end
	end

	assign run = (selQ == Nodes);

endmodule

//--- rtl/linkFifo.sv
module linkFifo #(
	parameter int Depth = meshPkg::LinkDepth
) (
	input logic clk,
	input logic rstN,
	linkIf.fifo link
);

	localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CntW = $clog2(Depth + 1);

	meshPkg::word_t mem [Depth];
	logic [PtrW-1:0] rdPtr;
	logic [PtrW-1:0] wrPtr;
	logic [CntW-1:0] used;
	logic [CntW-1:0] usedNext;
	logic doRead;
	logic doWrite;

	assign doRead = link.rd && !link.empty;
	// A pop in the same cycle frees the slot
	assign doWrite = link.wr && (!link.full || doRead);

	// Show-ahead output
	assign link.rData = mem[rdPtr];

	always_comb begin
		usedNext = used;
		if (doWrite && !doRead) begin
			usedNext = used + 1'b1;
		end else if (doRead && !doWrite) begin
			usedNext = used - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			used <= '0;
			link.full <= 1'b0;
			link.empty <= 1'b1;
		end else begin
			if (doWrite) begin
				wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doRead) begin
				rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
			end
			used <= usedNext;
			link.full <= (usedNext == CntW'(Depth));
			link.empty <= (usedNext == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (doWrite) begin
			mem[wrPtr] <= link.wData;
		end
	end

endmodule

//--- rtl/linkIf.sv
interface linkIf;

	// Write side
	logic wr;
	logic full;
	meshPkg::word_t wData;

	// Read side, rData shows the oldest word
	logic rd;
	logic empty;
	meshPkg::word_t rData;

	modport sender (
		output wr,
		output wData,
		input full
	);

	modport receiver (
		output rd,
		input empty,
		input rData
	);

	modport fifo (
		input wr,
		input wData,
		output full,
		input rd,
		output empty,
		output rData
	);

endinterface

//--- rtl/meshPkg.sv
package meshPkg;

	// Mesh geometry
	localparam int MeshCols = 4;
	localparam int MeshRows = 3;
	localparam int MeshNodes = MeshCols * MeshRows;

	// Data path and buffering
	localparam int WordWidth = 32;
	localparam int LoadDepth = 8;
	localparam int LinkDepth = 4;

	// Boot, link and output data word
	typedef logic [WordWidth-1:0] word_t;

	// Processor select, MeshNodes in here means run
	typedef logic [3:0] nodeSel_t;

	// Holds 0 up to LoadDepth
	typedef logic [3:0] loadCnt_t;

	// One write strobe per node
	typedef logic [MeshNodes-1:0] nodeMask_t;

	// Input the router granted last
	typedef enum logic [1:0] {
		grantLocal,
		grantEast,
		grantNorth
	} rrState_t;

endpackage
